// File: sim.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_ctrl_if.sv
rtl/microcode_rom.sv
rtl/mop_sequencer.sv
rtl/cpu_alu.sv
rtl/status_reg.sv
rtl/cpu_datapath.sv
rtl/cpu.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// File: Makefile
TOP := cpu_tb
SRCS := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/$(TOP): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f sim.f --top-module $(TOP) -o $(TOP)

run: obj_dir/$(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/cpu_tb.sv
`include "cpu_macros.svh"
`default_nettype none

module cpu_tb;
timeunit 1ns;
timeprecision 100ps;

localparam int CLK_PERIOD = 40;
localparam int N_TESTS = 6;
localparam int TEST_CYCLES = 200;

// 6502 opcode numbers
localparam logic [7:0] LDA_IMM = 8'ha9, LDX_IMM = 8'ha2, STA_ABS = 8'h8d, STX_ABS = 8'h8e;
localparam logic [7:0] ADC_IMM = 8'h69, SBC_IMM = 8'he9, AND_IMM = 8'h29, ORA_IMM = 8'h09;
localparam logic [7:0] EOR_IMM = 8'h49, CLC = 8'h18, SEC = 8'h38, TAX = 8'haa, INX = 8'he8;
localparam logic [7:0] BEQ = 8'hf0, BNE = 8'hd0, BCS = 8'hb0, BCC = 8'h90, JMP_ABS = 8'h4c;

logic clk;
logic n_reset;
logic [`CPU_ADDR_W-1:0] addr;
logic [7:0] data_in;
logic [7:0] data_out;
logic rw;

logic [7:0] mem [0:65535];
logic [7:0] prog [$];
logic [15:0] wr_addr_q [$];
logic [7:0] wr_data_q [$];
logic wr_pend;
logic [15:0] wr_pend_addr;
logic [7:0] wr_pend_data;
int errors;
int test_errors;
int tests_run;
int tests_failed;
integer seed;

cpu cpu_i (
	.clk(clk),
	.n_reset(n_reset),
	.addr(addr),
	.data_in(data_in),
	.data_out(data_out),
	.rw(rw)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

// memory answers reads and samples the write strobe mid-cycle
always @(negedge clk) begin
	data_in = mem[addr];
	wr_pend <= (rw === 1'b0);
	wr_pend_addr <= addr;
	wr_pend_data <= data_out;
end

always @(posedge clk)
	if (wr_pend) begin
		mem[wr_pend_addr] = wr_pend_data;
		wr_addr_q.push_back(wr_pend_addr);
		wr_data_q.push_back(wr_pend_data);
	end

function automatic logic [7:0] fill_byte(input logic [15:0] a);
	return a[15:8] ^ a[7:0] ^ 8'h5a;
endfunction

// {carry, sum} of A + M + C
function automatic logic [8:0] adc_ref(input logic [7:0] a, input logic [7:0] b, input logic c);
	int total;
	total = int'(a) + int'(b) + (c ? 1 : 0);
	return 9'(total);
endfunction

// A - M - (1 - C) with carry set when nothing was borrowed
function automatic logic [8:0] sbc_ref(input logic [7:0] a, input logic [7:0] b, input logic c);
	logic [8:0] d;
	d = {1'b0, a} - {1'b0, b} - {8'h00, ~c};
	return {~d[8], d[7:0]};
endfunction

task automatic check(input string name, input logic [15:0] actual, input logic [15:0] expected);
	if (actual !== expected) begin
		$display("error %s: got %h, expected %h", name, actual, expected);
		errors++;
		test_errors++;
	end
endtask

task automatic emit(input logic [7:0] b);
	prog.push_back(b);
endtask

task automatic emit_imm(input logic [7:0] op, input logic [7:0] v);
	emit(op);
	emit(v);
endtask

task automatic emit_abs(input logic [7:0] op, input logic [15:0] a);
	emit(op);
	emit(a[7:0]);
	emit(a[15:8]);
endtask

// jump to itself so the core idles without stores
task automatic emit_halt();
	logic [15:0] here;
	here = 16'(prog.size());
	emit_abs(JMP_ABS, here);
endtask

task automatic start_program();
	@(negedge clk);
	n_reset = 1'b0;
	for (int i = 0; i < 65536; i++)
		mem[i] = fill_byte(16'(i));
	for (int i = 0; i < prog.size(); i++)
		mem[i] = prog[i];
	wr_addr_q.delete();
	wr_data_q.delete();
	test_errors = 0;
	repeat (3) @(negedge clk);
	n_reset = 1'b1;
	check("addr", addr, `CPU_RESET_PC);	// first fetch address
	check("rw", {15'd0, rw}, 16'd1);
endtask

task automatic wait_writes(input int n);
	while (wr_addr_q.size() < n)
		@(negedge clk);
	repeat (16) @(negedge clk);	// halt loop must stay quiet
	check("write count", 16'(wr_addr_q.size()), 16'(n));
endtask

task automatic expect_write(input int idx, input logic [15:0] a, input logic [7:0] d);
	if (idx >= wr_addr_q.size()) begin
		$display("store number %0d never reached memory", idx);
		errors++;
		test_errors++;
	end else begin
		check("addr", wr_addr_q[idx], a);
		check("data_out", {8'h00, wr_data_q[idx]}, {8'h00, d});
	end
endtask

task automatic finish_test(input string name);
	tests_run++;
	if (test_errors == 0)
		$display("test %s: ok", name);
	else begin
		tests_failed++;
		$display("test %s: %0d mismatches", name, test_errors);
	end
	prog.delete();
endtask

task automatic test_load_store();
	emit_imm(LDA_IMM, 8'h5a);
	emit_imm(LDX_IMM, 8'hc3);
	emit_abs(STA_ABS, 16'h0200);
	emit_abs(STX_ABS, 16'h0201);
	emit_halt();
	start_program();
	wait_writes(2);
	expect_write(0, 16'h0200, 8'h5a);
	expect_write(1, 16'h0201, 8'hc3);
	finish_test("load_store");
endtask

// result store, then a marker for the carry picked by a branch
task automatic arith_case(input logic [7:0] op, input logic c, input logic [7:0] a,
		input logic [7:0] b, input logic [15:0] dst);
	emit(c ? SEC : CLC);
	emit_imm(LDA_IMM, a);
	emit_imm(op, b);
	emit_abs(STA_ABS, dst);
	if (op == ADC_IMM) begin
		emit_imm(LDX_IMM, 8'hc1);
		emit_imm(BCS, 8'h02);	// skips the clear marker
		emit_imm(LDX_IMM, 8'hc0);
	end else begin
		emit_imm(LDX_IMM, 8'hc0);
		emit_imm(BCC, 8'h02);
		emit_imm(LDX_IMM, 8'hc1);
	end
	emit_abs(STX_ABS, dst + 16'h0001);
endtask

task automatic test_add_sub();
	logic [7:0] a_v [4] = '{8'h7f, 8'hf0, 8'h50, 8'h10};
	logic [7:0] b_v [4] = '{8'h01, 8'h20, 8'h30, 8'h20};
	logic c_v [4] = '{1'b0, 1'b1, 1'b1, 1'b0};
	logic [8:0] r;
	for (int i = 0; i < 4; i++)
		arith_case(i < 2 ? ADC_IMM : SBC_IMM, c_v[i], a_v[i], b_v[i], 16'h0200 + 16'(2 * i));
	emit_halt();
	start_program();
	wait_writes(8);
	for (int i = 0; i < 4; i++) begin
		r = (i < 2) ? adc_ref(a_v[i], b_v[i], c_v[i]) : sbc_ref(a_v[i], b_v[i], c_v[i]);
		expect_write(2 * i, 16'h0200 + 16'(2 * i), r[7:0]);
		expect_write(2 * i + 1, 16'h0201 + 16'(2 * i), r[8] ? 8'hc1 : 8'hc0);
	end
	finish_test("add_sub");
endtask

task automatic test_logic();
	logic [7:0] a_v [3];
	logic [7:0] b_v [3];
	logic [15:0] dst;
	for (int i = 0; i < 3; i++) begin
		a_v[i] = 8'($random(seed));
		b_v[i] = 8'($random(seed));
		dst = 16'h0210 + 16'(3 * i);
		emit_imm(LDA_IMM, a_v[i]);
		emit_imm(AND_IMM, b_v[i]);
		emit_abs(STA_ABS, dst);
		emit_imm(LDA_IMM, a_v[i]);
		emit_imm(ORA_IMM, b_v[i]);
		emit_abs(STA_ABS, dst + 16'h0001);
		emit_imm(LDA_IMM, a_v[i]);
		emit_imm(EOR_IMM, b_v[i]);
		emit_abs(STA_ABS, dst + 16'h0002);
	end
	emit_halt();
	start_program();
	wait_writes(9);
	for (int i = 0; i < 3; i++) begin
		dst = 16'h0210 + 16'(3 * i);
		expect_write(3 * i, dst, a_v[i] & b_v[i]);
		expect_write(3 * i + 1, dst + 16'h0001, a_v[i] | b_v[i]);
		expect_write(3 * i + 2, dst + 16'h0002, a_v[i] ^ b_v[i]);
	end
	finish_test("logic");
endtask

task automatic test_branch_zero();
	logic [7:0] op_v [4] = '{BEQ, BNE, BEQ, BNE};
	logic [7:0] a_v [4] = '{8'h00, 8'h00, 8'h37, 8'h37};
	logic taken [4];
	int n;
	n = 0;
	for (int i = 0; i < 4; i++) begin
		taken[i] = (op_v[i] == BEQ) ? (a_v[i] == 8'h00) : (a_v[i] != 8'h00);
		if (!taken[i])
			n++;
		emit_imm(LDX_IMM, 8'hb1 + 8'(i));
		emit_imm(LDA_IMM, a_v[i]);
		emit_imm(op_v[i], 8'h03);	// over the marker store
		emit_abs(STX_ABS, 16'h0220 + 16'(i));
	end
	emit_abs(STA_ABS, 16'h0224);
	emit_halt();
	start_program();
	wait_writes(n + 1);
	n = 0;
	for (int i = 0; i < 4; i++)
		if (!taken[i]) begin
			expect_write(n, 16'h0220 + 16'(i), 8'hb1 + 8'(i));
			n++;
		end
	expect_write(n, 16'h0224, 8'h37);
	finish_test("branch_zero");
endtask

task automatic test_transfer_jump();
	logic [15:0] over;
	emit_imm(LDA_IMM, 8'hff);
	emit(TAX);
	emit(INX);
	emit_abs(STX_ABS, 16'h0230);
	over = 16'(prog.size()) + 16'd6;	// past the jmp and one store
	emit_abs(JMP_ABS, over);
	emit_abs(STA_ABS, 16'h0231);
	emit_abs(STA_ABS, 16'h0232);
	emit_halt();
	start_program();
	wait_writes(2);
	expect_write(0, 16'h0230, 8'(8'hff + 8'h01));
	expect_write(1, 16'h0232, 8'hff);
	finish_test("transfer_jump");
endtask

task automatic test_unknown_opcode();
	emit_imm(LDA_IMM, 8'h96);
	emit(8'hea);	// not decoded by this core
	emit_abs(STA_ABS, 16'h0240);
	emit_imm(LDX_IMM, 8'h5c);
	emit(8'h02);
	emit(8'hff);
	emit_abs(STX_ABS, 16'h0241);
	emit_halt();
	start_program();
	wait_writes(2);
	expect_write(0, 16'h0240, 8'h96);
	expect_write(1, 16'h0241, 8'h5c);
	finish_test("unknown_opcode");
endtask

initial begin
	n_reset = 1'b0;
	data_in = 8'h00;
	seed = 32'hba48cefc;
	errors = 0;
	test_errors = 0;
	tests_run = 0;
	tests_failed = 0;
	test_load_store();
	test_add_sub();
	test_logic();
	test_branch_zero();
	test_transfer_jump();
	test_unknown_opcode();
	$display("summary: %0d run, %0d failing, %0d check errors", tests_run, tests_failed, errors);
	if (tests_failed == 0)
		$display("all tests passed");
	else
		$display("tests failed");
	$finish;
end

initial begin
	#(N_TESTS * TEST_CYCLES * CLK_PERIOD);
	$display("timeout: the core stopped storing before the tests were done");
	$display("tests failed");
	$finish;
end

endmodule

`default_nettype wire

// File: testbench/cpu_props.sv
`default_nettype none

module cpu_props (
	input logic clk,
	input logic n_reset,
	input logic rw,
	input logic [7:0] data_out
);
timeunit 1ns;
timeprecision 100ps;

rw_known: assert property (@(posedge clk) disable iff (!n_reset) !$isunknown(rw))
	else $error("rw is unknown after reset");

// first cycle out of reset is the opcode fetch
rw_high_after_reset: assert property (@(posedge clk) $rose(n_reset) |-> rw)
	else $error("rw low in the first cycle after reset");

data_known_on_write: assert property (@(posedge clk) disable iff (!n_reset)
	!rw |-> !$isunknown(data_out))
	else $error("data_out unknown during a write strobe");

endmodule

bind cpu cpu_props props_i (
	.clk(clk),
	.n_reset(n_reset),
	.rw(rw),
	.data_out(data_out)
);

`default_nettype wire

// File: rtl/cpu.sv
`include "cpu_macros.svh"
`default_nettype none

module cpu (
	input logic clk,
	input logic n_reset,
	output logic [`CPU_ADDR_W-1:0] addr,
	input logic [7:0] data_in,
	output logic [7:0] data_out,
	output logic rw
);

logic [7:0] sb, db, alu_result;
logic alu_carry, carry;

cpu_ctrl_if ctrl ();

mop_sequencer seq0 (
	.clk(clk),
	.n_reset(n_reset),
	.ctrl(ctrl.seq)
);

cpu_datapath dp0 (
	.clk(clk),
	.n_reset(n_reset),
	.ctrl(ctrl.dp),
	.data_in(data_in),
	.addr(addr),
	.data_out(data_out),
	.rw(rw),
	.alu_result(alu_result),
	.alu_carry(alu_carry),
	.carry(carry),
	.sb(sb),
	.db(db)
);

cpu_alu alu0 (
	.clk(clk),
	.n_reset(n_reset),
	.ctrl(ctrl.alu),
	.sb(sb),
	.db(db),
	.carry_in(carry),
	.result(alu_result),
	.carry_out(alu_carry)
);

status_reg p0 (
	.clk(clk),
	.n_reset(n_reset),
	.ctrl(ctrl.flags),
	.db(db),
	.alu_carry(alu_carry),
	.carry(carry)
);

endmodule

`default_nettype wire

// File: rtl/cpu_datapath.sv
`include "cpu_macros.svh"
`default_nettype none

module cpu_datapath import cpu_pkg::*; (
	input logic clk,
	input logic n_reset,
	cpu_ctrl_if.dp ctrl,
	input logic [7:0] data_in,
	output logic [`CPU_ADDR_W-1:0] addr,
	output logic [7:0] data_out,
	output logic rw,
	input logic [7:0] alu_result,
	input logic alu_carry,
	input logic carry,
	output logic [7:0] sb,
	output logic [7:0] db
);

logic [7:0] a, x, y, sp, dl, sb_reg;
logic [`CPU_ADDR_W-1:0] pc, pc_next, ab;

assign ctrl.opcode = data_in;	// dispatch sees the byte being fetched
assign rw = ~ctrl.mop.wr;
assign addr = ab;

always_comb
	case (ctrl.mop.sb)
	SB_SP:		sb_reg = sp;
	SB_X:		sb_reg = x;
	SB_Y:		sb_reg = y;
	SB_A:		sb_reg = a;
	default:	sb_reg = alu_result;
	endcase

always_comb
	case (ctrl.mop.db)
	DB_PCL:		db = pc[7:0];
	DB_PCH:		db = pc[15:8];
	DB_SB:		db = sb_reg;
	DB_A:		db = a;
	default:	db = dl;
	endcase

assign sb = (ctrl.mop.sb == SB_DB) ? db : sb_reg;

always_comb
	if (ctrl.mop.pc_load & ctrl.mop.pc_inc)
		pc_next = pc + {{8{dl[7]}}, dl};	// relative branch
	else if (ctrl.mop.pc_load)
		pc_next = {dl, alu_result};
	else
		pc_next = pc + {15'd0, ctrl.mop.pc_inc};

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		pc <= `CPU_RESET_PC;
		ab <= `CPU_RESET_PC;
	end else begin
		pc <= pc_next;
		if (ctrl.mop.ad_ab)
			ab <= (ctrl.mop.ad == AD_ABS) ? {dl, alu_result} : pc_next;
	end

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		a <= 8'h00;
		x <= 8'h00;
		y <= 8'h00;
		sp <= 8'h00;
	end else begin
		if (ctrl.mop.sb_a)
			a <= sb;
		if (ctrl.mop.sb_x)
			x <= sb;
		if (ctrl.mop.sb_y)
			y <= sb;
		if (ctrl.mop.sb_sp)
			sp <= sb;
	end

always_ff @(posedge clk) begin
	dl <= data_in;
	data_out <= db;
end

endmodule

`default_nettype wire

// File: rtl/status_reg.sv
`default_nettype none

module status_reg import cpu_pkg::*; (
	input logic clk,
	input logic n_reset,
	cpu_ctrl_if.flags ctrl,
	input logic [7:0] db,
	input logic alu_carry,
	output logic carry
);

logic n, v, z, c;

assign carry = c;

always_comb begin
	logic sel;
	sel = (ctrl.mop.br_cond == BR_C) ? c : z;
	ctrl.br = sel ^ ctrl.mop.br_inv;
end

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		n <= 1'b0;
		v <= 1'b0;
		z <= 1'b0;
		c <= 1'b0;
	end else
		case (ctrl.mop.p_upd)
		P_NZ: begin
			n <= db[7];
			z <= (db == 8'h00);
		end
		P_NZC, P_NVZC: begin
			n <= db[7];
			z <= (db == 8'h00);
			c <= alu_carry;
			if (ctrl.mop.p_upd == P_NVZC)
				v <= ctrl.avr;
		end
		P_CLR_C:	c <= 1'b0;
		P_SET_C:	c <= 1'b1;
		default: ;
		endcase

endmodule

`default_nettype wire

// File: rtl/cpu_alu.sv
`default_nettype none

module cpu_alu import cpu_pkg::*; (
	input logic clk,
	input logic n_reset,
	cpu_ctrl_if.alu ctrl,
	input logic [7:0] sb,
	input logic [7:0] db,
	input logic carry_in,
	output logic [7:0] result,
	output logic carry_out
);

logic [7:0] ai, bi;
logic cin, sh_in, ovf;
logic [8:0] sum;

always_comb begin
	ai = (ctrl.mop.ai == AI_SB) ? sb : 8'h00;
	case (ctrl.mop.bi)
	BI_NDB:		bi = ~db;
	BI_ONE:		bi = 8'h01;
	default:	bi = db;
	endcase
	sh_in = ctrl.mop.alu_c & carry_in;
	if (ctrl.mop.alu == ALU_SUB)
		cin = ctrl.mop.alu_c ? carry_in : 1'b1;	// no borrow by default
	else
		cin = sh_in;
	sum = {1'b0, ai} + {1'b0, bi} + {8'h00, cin};
	ovf = ~(ai[7] ^ bi[7]) & (ai[7] ^ sum[7]);
end

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		result <= 8'h00;
		carry_out <= 1'b0;
		ctrl.avr <= 1'b0;
	end else begin
		{carry_out, result} <= sum;
		ctrl.avr <= ovf;
		case (ctrl.mop.alu)
		ALU_SL:		{carry_out, result} <= {ai, sh_in};
		ALU_SR:		{result, carry_out} <= {sh_in, ai};
		ALU_AND:	result <= ai & bi;
		ALU_OR:		result <= ai | bi;
		ALU_EOR:	result <= ai ^ bi;
		ALU_PASS:	result <= bi;
		default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/mop_sequencer.sv
`include "cpu_macros.svh"
`default_nettype none

module mop_sequencer import cpu_pkg::*; (
	input logic clk,
	input logic n_reset,
	cpu_ctrl_if.seq ctrl
);

logic [`CPU_MOP_ADDR_W-1:0] mop_addr, mop_addr_next, dispatch;
mop_t rom_mop;

microcode_rom rom (
	.addr(mop_addr),
	.opcode(ctrl.opcode),
	.mop(rom_mop),
	.dispatch(dispatch)
);

assign ctrl.mop = rom_mop;

always_comb
	case (rom_mop.seq)
	SEQ_NEXT:	mop_addr_next = mop_addr + 1'b1;
	SEQ_DISPATCH:	mop_addr_next = dispatch;
	SEQ_BRANCH:	mop_addr_next = ctrl.br ? mop_addr + 1'b1 : '0;
	default:	mop_addr_next = '0;	// back to fetch
	endcase

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset)
		mop_addr <= '0;
	else
		mop_addr <= mop_addr_next;

endmodule

`default_nettype wire

// File: rtl/microcode_rom.sv
`include "cpu_macros.svh"
`default_nettype none

module microcode_rom import cpu_pkg::*; (
	input logic [`CPU_MOP_ADDR_W-1:0] addr,
	input logic [7:0] opcode,
	output mop_t mop,
	output logic [`CPU_MOP_ADDR_W-1:0] dispatch
);

localparam logic [`CPU_MOP_ADDR_W-1:0] M_FETCH = 0, M_NOP = 1, M_LDA = 2, M_LDX = 4;
localparam logic [`CPU_MOP_ADDR_W-1:0] M_ADC = 6, M_SBC = 9, M_AND = 12, M_ORA = 15;
localparam logic [`CPU_MOP_ADDR_W-1:0] M_EOR = 18, M_CLC = 21, M_SEC = 22, M_TAX = 23;
localparam logic [`CPU_MOP_ADDR_W-1:0] M_INX = 24, M_BEQ = 26, M_BNE = 28, M_BCS = 30;
localparam logic [`CPU_MOP_ADDR_W-1:0] M_BCC = 32, M_JMP = 34, M_STA = 37, M_STX = 41;

// adds an opcode fetch at PC to any microword
function automatic mop_t w_fetch(input mop_t m);
	m.ad = AD_PC;
	m.ad_ab = 1'b1;
	m.pc_inc = 1'b1;
	m.seq = SEQ_DISPATCH;
	return m;
endfunction

function automatic mop_t w_operand();
	mop_t m;
	m = '0;
	m.ad_ab = 1'b1;
	m.pc_inc = 1'b1;
	return m;
endfunction

function automatic mop_t w_alu(input alu_op_t op, input alu_b_t b, input logic c);
	mop_t m;
	m = '0;
	m.db = DB_DL;
	m.sb = SB_A;
	m.ai = AI_SB;
	m.bi = b;
	m.alu = op;
	m.alu_c = c;
	return m;
endfunction

// result back into A with flags from the data bus
function automatic mop_t w_wb(input p_upd_t p);
	mop_t m;
	m = '0;
	m.sb = SB_ALU;
	m.sb_a = 1'b1;
	m.db = DB_SB;
	m.p_upd = p;
	return w_fetch(m);
endfunction

function automatic mop_t w_branch(input br_cond_t cond, input logic inv);
	mop_t m;
	m = w_operand();
	m.br_cond = cond;
	m.br_inv = inv;
	m.seq = SEQ_BRANCH;
	return m;
endfunction

function automatic mop_t w_taken();
	mop_t m;
	m = '0;
	m.pc_load = 1'b1;
	m.pc_inc = 1'b1;
	m.ad_ab = 1'b1;
	m.seq = SEQ_FETCH;
	return m;
endfunction

always_comb
	case (opcode)
	OP_LDA_IMM:	dispatch = M_LDA;
	OP_LDX_IMM:	dispatch = M_LDX;
	OP_ADC_IMM:	dispatch = M_ADC;
	OP_SBC_IMM:	dispatch = M_SBC;
	OP_AND_IMM:	dispatch = M_AND;
	OP_ORA_IMM:	dispatch = M_ORA;
	OP_EOR_IMM:	dispatch = M_EOR;
	OP_CLC:		dispatch = M_CLC;
	OP_SEC:		dispatch = M_SEC;
	OP_TAX:		dispatch = M_TAX;
	OP_INX:		dispatch = M_INX;
	OP_BEQ:		dispatch = M_BEQ;
	OP_BNE:		dispatch = M_BNE;
	OP_BCS:		dispatch = M_BCS;
	OP_BCC:		dispatch = M_BCC;
	OP_JMP_ABS:	dispatch = M_JMP;
	OP_STA_ABS:	dispatch = M_STA;
	OP_STX_ABS:	dispatch = M_STX;
	default:	dispatch = M_NOP;
	endcase

always_comb begin
	mop = '0;
	case (addr)
	M_FETCH:	mop = w_fetch('0);
	M_LDA, M_LDX, M_ADC, M_SBC, M_AND, M_ORA, M_EOR:
		mop = w_operand();
	M_JMP, M_STA, M_STX:
		mop = w_operand();		// low address byte
	M_LDA + 1: begin
		mop.sb = SB_DB;
		mop.sb_a = 1'b1;
		mop.p_upd = P_NZ;
		mop = w_fetch(mop);
	end
	M_LDX + 1: begin
		mop.sb = SB_DB;
		mop.sb_x = 1'b1;
		mop.p_upd = P_NZ;
		mop = w_fetch(mop);
	end
	M_ADC + 1:	mop = w_alu(ALU_ADD, BI_DB, 1'b1);
	M_ADC + 2:	mop = w_wb(P_NVZC);
	M_SBC + 1:	mop = w_alu(ALU_SUB, BI_NDB, 1'b1);
	M_SBC + 2:	mop = w_wb(P_NVZC);
	M_AND + 1:	mop = w_alu(ALU_AND, BI_DB, 1'b0);
	M_AND + 2:	mop = w_wb(P_NZ);
	M_ORA + 1:	mop = w_alu(ALU_OR, BI_DB, 1'b0);
	M_ORA + 2:	mop = w_wb(P_NZ);
	M_EOR + 1:	mop = w_alu(ALU_EOR, BI_DB, 1'b0);
	M_EOR + 2:	mop = w_wb(P_NZ);
	M_CLC: begin
		mop.p_upd = P_CLR_C;
		mop.seq = SEQ_FETCH;
	end
	M_SEC: begin
		mop.p_upd = P_SET_C;
		mop.seq = SEQ_FETCH;
	end
	M_TAX: begin
		mop.sb = SB_A;
		mop.sb_x = 1'b1;
		mop.db = DB_SB;
		mop.p_upd = P_NZ;
		mop.seq = SEQ_FETCH;
	end
	M_INX: begin
		mop.sb = SB_X;
		mop.ai = AI_SB;
		mop.bi = BI_ONE;
	end
	M_INX + 1: begin
		mop.sb = SB_ALU;
		mop.sb_x = 1'b1;
		mop.db = DB_SB;
		mop.p_upd = P_NZ;
		mop = w_fetch(mop);
	end
	M_BEQ:		mop = w_branch(BR_Z, 1'b0);
	M_BNE:		mop = w_branch(BR_Z, 1'b1);
	M_BCS:		mop = w_branch(BR_C, 1'b0);
	M_BCC:		mop = w_branch(BR_C, 1'b1);
	M_BEQ + 1, M_BNE + 1, M_BCS + 1, M_BCC + 1:
		mop = w_taken();
	M_JMP + 1, M_STA + 1, M_STX + 1: begin
		mop = w_operand();		// high byte while the alu holds the low byte
		mop.alu = ALU_PASS;
	end
	M_JMP + 2: begin
		mop.pc_load = 1'b1;
		mop.ad_ab = 1'b1;
		mop.seq = SEQ_FETCH;
	end
	M_STA + 2, M_STA + 3: begin
		mop.db = DB_A;
		mop.ad = (addr == M_STA + 2) ? AD_ABS : AD_PC;
		mop.ad_ab = 1'b1;
		mop.wr = (addr == M_STA + 3);
		mop.seq = (addr == M_STA + 3) ? SEQ_FETCH : SEQ_NEXT;
	end
	M_STX + 2, M_STX + 3: begin
		mop.sb = SB_X;
		mop.db = DB_SB;
		mop.ad = (addr == M_STX + 2) ? AD_ABS : AD_PC;
		mop.ad_ab = 1'b1;
		mop.wr = (addr == M_STX + 3);
		mop.seq = (addr == M_STX + 3) ? SEQ_FETCH : SEQ_NEXT;
	end
	default:	mop.seq = SEQ_FETCH;	// nop and unused entries
	endcase
end

endmodule

`default_nettype wire

// File: rtl/cpu_ctrl_if.sv
`default_nettype none

interface cpu_ctrl_if import cpu_pkg::*; ();
	mop_t mop;		// current microword
	logic [7:0] opcode;	// byte being fetched
	logic br;		// branch condition met
	logic avr;		// registered alu overflow

	modport seq (output mop, input br, input opcode);
	modport dp (input mop, output opcode);
	modport alu (input mop, output avr);
	modport flags (input mop, input avr, output br);
endinterface

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef enum logic [2:0] {
		ALU_ADD = 3'h0, ALU_SUB = 3'h1, ALU_SL = 3'h2, ALU_SR = 3'h3,
		ALU_AND = 3'h4, ALU_OR = 3'h5, ALU_EOR = 3'h6, ALU_PASS = 3'h7
	} alu_op_t;

	typedef enum logic {AI_ZERO = 1'b0, AI_SB = 1'b1} alu_a_t;

	typedef enum logic [1:0] {BI_DB = 2'h0, BI_NDB = 2'h1, BI_ONE = 2'h2} alu_b_t;

	typedef enum logic [2:0] {
		DB_DL = 3'h0, DB_PCL = 3'h1, DB_PCH = 3'h2, DB_SB = 3'h3, DB_A = 3'h4
	} db_src_t;

	typedef enum logic [2:0] {
		SB_ALU = 3'h0, SB_SP = 3'h1, SB_X = 3'h2, SB_Y = 3'h3, SB_A = 3'h4, SB_DB = 3'h5
	} sb_src_t;

	typedef enum logic {AD_PC = 1'b0, AD_ABS = 1'b1} ad_src_t;

	typedef enum logic [2:0] {
		P_NONE = 3'h0, P_NZ = 3'h1, P_NZC = 3'h2, P_NVZC = 3'h3, P_CLR_C = 3'h4, P_SET_C = 3'h5
	} p_upd_t;

	typedef enum logic {BR_Z = 1'b0, BR_C = 1'b1} br_cond_t;

	typedef enum logic [1:0] {
		SEQ_NEXT = 2'h0, SEQ_DISPATCH = 2'h1, SEQ_FETCH = 2'h2, SEQ_BRANCH = 2'h3
	} seq_t;

	typedef enum logic [7:0] {
		OP_ORA_IMM = 8'h09, OP_CLC = 8'h18, OP_AND_IMM = 8'h29, OP_SEC = 8'h38,
		OP_EOR_IMM = 8'h49, OP_JMP_ABS = 8'h4C, OP_ADC_IMM = 8'h69, OP_STA_ABS = 8'h8D,
		OP_STX_ABS = 8'h8E, OP_BCC = 8'h90, OP_LDX_IMM = 8'hA2, OP_LDA_IMM = 8'hA9,
		OP_TAX = 8'hAA, OP_BCS = 8'hB0, OP_BNE = 8'hD0, OP_INX = 8'hE8,
		OP_SBC_IMM = 8'hE9, OP_BEQ = 8'hF0
	} opcode_t;

	typedef struct packed {
		alu_op_t alu;		// 3
		logic alu_c;		// use carry flag as carry in
		alu_a_t ai;
		alu_b_t bi;		// 2
		db_src_t db;		// 3
		sb_src_t sb;		// 3
		logic sb_a, sb_x, sb_y, sb_sp;
		ad_src_t ad;
		logic ad_ab;		// load address register
		logic pc_load;		// with pc_inc: relative branch
		logic pc_inc;
		p_upd_t p_upd;		// 3
		br_cond_t br_cond;
		logic br_inv;
		logic wr;
		logic [2:0] spare;	// kept zero
		seq_t seq;		// 2
	} mop_t;

endpackage

`default_nettype wire

// File: rtl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH
`default_nettype none

`define CPU_ADDR_W 16
`define CPU_MOP_ADDR_W 8
`define CPU_RESET_PC 16'h0000

`default_nettype wire
`endif
